/* Bender.yml */
package:
  name: sprite_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/sprite_pkg.sv
      - verilog/sprite_attr_ram.sv
      - verilog/sprite_palette.sv
      - verilog/sprite_engine.sv
      - verilog/pixel_unpack.sv
      - verilog/line_buffer.sv
      - verilog/sprite_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - tests/sprite_checker.sv
      - tests/sprite_monitor.sv
      - tests/sprite_tb.sv

/* tests/sprite_checker.sv */
`include "sprite_cfg.svh"
`default_nettype none

// handshake properties of the sprite engine, bound into every engine instance
module sprite_checker (
	input wire                          clk,
	input wire                          reset,
	input wire                          line_start,
	input wire                          fetch_valid,
	input wire                          fetch_ready,
	input wire sprite_pkg::fetch_req_t  fetch_req,
	input wire                          rsp_valid,
	input wire                          rsp_ready,
	input wire                          job_valid,
	input wire                          job_ready,
	input wire sprite_pkg::word_job_t   job
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0;    // read by the testbench top
	int in_flight;       // accepted requests not yet answered
	logic started = 1'b0;    // a line_start seen since reset

	always @(posedge clk)
	begin
		if (reset)
		begin
			in_flight <= 0;
			started <= 1'b0;
		end
		else
		begin
			in_flight <= in_flight + int'(fetch_valid && fetch_ready)
				- int'(rsp_valid && rsp_ready);
			if (line_start)
				started <= 1'b1;
		end
	end

	// --------------------------------------------------
	// fetch port
	// --------------------------------------------------
	fetch_hold: assert property (@(posedge clk) disable iff (reset)
		fetch_valid && !fetch_ready |=> fetch_valid && $stable(fetch_req))
	else
	begin
		fail_cnt++;
		$error("fetch request dropped or changed before its transfer");
	end

	one_outstanding: assert property (@(posedge clk) disable iff (reset) in_flight <= 1)
	else
	begin
		fail_cnt++;
		$error("more than one fetch outstanding");
	end

	// ready only while a request waits for its answer
	ready_while_waiting: assert property (@(posedge clk) disable iff (reset)
		rsp_ready == (in_flight != 0))
	else
	begin
		fail_cnt++;
		$error("rsp_ready does not match the outstanding request");
	end

	// --------------------------------------------------
	// engine to unpacker
	// --------------------------------------------------
	job_hold: assert property (@(posedge clk) disable iff (reset)
		job_valid && !job_ready && !line_start |=> job_valid && $stable(job))    // abort may flush
	else
	begin
		fail_cnt++;
		$error("job dropped or changed before the unpacker took it");
	end

	quiet_after_reset: assert property (@(posedge clk) disable iff (reset)
		!started |-> !job_valid && !fetch_valid)
	else
	begin
		fail_cnt++;
		$error("job_valid or fetch_valid high before the first line_start");
	end

endmodule

bind sprite_engine sprite_checker chk0 (
	.clk         (clk),
	.reset       (reset),
	.line_start  (line_start),
	.fetch_valid (fetch_valid),
	.fetch_ready (fetch_ready),
	.fetch_req   (fetch_req),
	.rsp_valid   (rsp_valid),
	.rsp_ready   (rsp_ready),
	.job_valid   (job_valid),
	.job_ready   (job_ready),
	.job         (job)
);

`default_nettype wire

/* tests/sprite_monitor.sv */
`include "sprite_cfg.svh"
`default_nettype none

// reference renderer, compares each displayed pixel 2 cycles after its tick
module sprite_monitor (
	input wire                          clk,
	input wire                          reset,
	input wire                          line_start,
	input wire                          frame_start,
	input wire                          pix_tick,
	input wire                          fetch_valid,
	input wire                          pix_on,
	input wire sprite_pkg::color_t      pix_color,
	input var sprite_pkg::sprite_attr_t attr_tab [`SPR_COUNT],
	input var sprite_pkg::color_t       pal_tab [`SPR_PAL_N*16],
	input var sprite_pkg::mem_word_t    mem_tab [512],
	output int                          checked,
	output int                          pix_errors,
	output int                          other_errors
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CHECK_FROM = 12;    // first line of the second frame

	logic exp_on [`SPR_LINE_W];
	sprite_pkg::color_t exp_col [`SPR_LINE_W];
	int line_idx = -1;
	int build_line = 0;
	int shown_line = 0;
	logic seen_line = 1'b0;
	int col = 0;
	logic v1 = 1'b0;    // tick pipeline, 2 stages
	logic v2 = 1'b0;
	int col1 = 0;
	int col2 = 0;

	initial
	begin
		checked = 0;
		pix_errors = 0;
		other_errors = 0;
	end

	// draw one line from the attribute, palette and memory images
	task render(input int ln);
		sprite_pkg::sprite_attr_t a;
		sprite_pkg::mem_word_t w;
		int bpp;
		int ppw;
		int span;
		int row;
		int addr;
		int idx;
		int pos;
		for (int i = 0; i < `SPR_LINE_W; i++)
		begin
			exp_on[i] = 1'b0;
			exp_col[i] = '0;
		end
		for (int s = 0; s < `SPR_COUNT; s++)    // later sprites win
		begin
			a = attr_tab[s];
			if (a.mode == sprite_pkg::MODE_OFF || a.width == 0)
				continue;
			if (ln < int'(a.y) || ln >= int'(a.y) + int'(a.height))
				continue;
			bpp = (a.mode == sprite_pkg::MODE_16C) ? 4 : 2;
			ppw = 16 / bpp;
			span = int'(a.width) * ppw;
			row = ln - int'(a.y);
			if (a.flipy)
				row = int'(a.height) - 1 - row;    // mirrored row choice
			for (int p = 0; p < span; p++)
			begin
				addr = int'(a.base) + row * int'(a.width) + p / ppw;
				w = mem_tab[addr % 512];
				idx = (int'(w) >> (16 - bpp * (p % ppw + 1))) & ((1 << bpp) - 1);    // msb first
				pos = a.flipx ? int'(a.x) + span - 1 - p : int'(a.x) + p;
				if (idx != 0 && pos >= 0 && pos < `SPR_LINE_W)
				begin
					exp_on[pos] = 1'b1;
					exp_col[pos] = pal_tab[int'(a.pal) * 16 + idx];
				end
			end
		end
	endtask

	task compare(input int c);
		checked++;
		if (pix_on !== exp_on[c] || (exp_on[c] && pix_color !== exp_col[c]))
		begin
			pix_errors++;
			$display("Fail %0t: line %0d col %0d shows on=%b color=%h, expected on=%b color=%h",
				$time, shown_line, c, pix_on, pix_color, exp_on[c], exp_col[c]);
		end
	endtask

	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (!seen_line && (pix_on !== 1'b0 || fetch_valid !== 1'b0))
			begin
				other_errors++;
				$display("Fail %0t: pix_on or fetch_valid high before the first line_start", $time);
			end
			if (v2 && line_idx >= CHECK_FROM)
				compare(col2);
			v2 = v1;
			col2 = col1;
			v1 = pix_tick;
			col1 = col;
			if (line_start)
			begin
				seen_line = 1'b1;
				line_idx++;
				shown_line = build_line;    // built during the line just ended
				build_line = frame_start ? 0 : build_line + 1;
				render(shown_line);
				col = 0;
			end
			else if (pix_tick)
				col++;
		end
	end

endmodule

`default_nettype wire

/* tests/sprite_stim.txt */
# A num mode flipx flipy pal x y width_words height_lines base_hex  (mode 0 off, 1 4c, 2 16c)
# P pal idx colour_hex | M word_addr_hex word_hex | F frames
F 3
A 0 2 0 0 1 20 0 2 4 00000
A 1 1 1 0 2 24 2 1 6 00010
A 2 2 0 1 3 100 1 2 4 00000
A 3 0 0 0 1 50 0 2 4 00000
A 4 2 0 0 1 310 5 3 3 00020
A 5 1 0 0 2 0 20 1 2 00010
A 6 1 1 1 2 26 3 2 2 00030
A 7 2 0 0 2 312 6 1 1 00004
A 31 2 0 0 1 200 9 2 3 00000
# palette 1, full ramp
P 1 1 01
P 1 2 05
P 1 3 09
P 1 4 0D
P 1 5 11
P 1 6 15
P 1 7 19
P 1 8 1D
P 1 9 21
P 1 10 25
P 1 11 29
P 1 12 2D
P 1 13 31
P 1 14 35
P 1 15 39
# palette 2, 4c entries plus index 15
P 2 1 3E
P 2 2 2A
P 2 3 14
P 2 15 07
# palette 3, low entries only
P 3 1 30
P 3 2 0C
P 3 3 03
P 3 4 3F
# sprite 0 rows, also used by 2, 7 and 31
M 00000 1234
M 00001 5670
M 00002 0AB0
M 00003 C0DE
M 00004 FFFF
M 00005 1001
M 00006 89AB
M 00007 CDEF
# sprite 1 rows
M 00010 E4E4
M 00011 1B1B
M 00012 5555
M 00013 AAAA
M 00014 FF00
M 00015 0C30
# sprite 4 rows, clipped at the right edge
M 00020 1111
M 00021 2222
M 00022 3333
M 00023 4444
M 00024 5555
M 00025 6666
M 00026 7777
M 00027 8888
M 00028 9999
# sprite 6 rows
M 00030 9C63
M 00031 3690
M 00032 0FF0
M 00033 A5A5

/* tests/sprite_tb.sv */
`include "sprite_cfg.svh"
`default_nettype none

module sprite_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int LINE_CYC = 600;
	localparam int LINES_PER_FRAME = 12;
	localparam int PIX_START = 10;
	localparam int MEM_WORDS = 512;

	logic clk = 1'b0;
	logic reset;
	logic line_start;
	logic frame_start;
	logic pix_tick;
	sprite_pkg::host_wr_t host_wr;
	logic fetch_valid;
	sprite_pkg::fetch_req_t fetch_req;
	logic fetch_ready;
	logic rsp_valid;
	sprite_pkg::fetch_rsp_t rsp;
	logic rsp_ready;
	sprite_pkg::color_t pix_color;
	logic pix_on;

	sprite_pkg::sprite_attr_t attr_tab [`SPR_COUNT];
	sprite_pkg::color_t pal_tab [`SPR_PAL_N*16];
	sprite_pkg::mem_word_t mem_tab [MEM_WORDS];
	int frames = 0;
	int unsigned rand_state = 54173;
	int checked;
	int pix_errors;
	int other_errors;

	sprite_unit dut0 (
		.clk         (clk),
		.reset       (reset),
		.line_start  (line_start),
		.frame_start (frame_start),
		.pix_tick    (pix_tick),
		.host_wr     (host_wr),
		.fetch_valid (fetch_valid),
		.fetch_req   (fetch_req),
		.fetch_ready (fetch_ready),
		.rsp_valid   (rsp_valid),
		.rsp         (rsp),
		.rsp_ready   (rsp_ready),
		.pix_color   (pix_color),
		.pix_on      (pix_on)
	);

	sprite_monitor mon0 (
		.clk          (clk),
		.reset        (reset),
		.line_start   (line_start),
		.frame_start  (frame_start),
		.pix_tick     (pix_tick),
		.fetch_valid  (fetch_valid),
		.pix_on       (pix_on),
		.pix_color    (pix_color),
		.attr_tab     (attr_tab),
		.pal_tab      (pal_tab),
		.mem_tab      (mem_tab),
		.checked      (checked),
		.pix_errors   (pix_errors),
		.other_errors (other_errors)
	);

	initial
	begin
		forever #10 clk = ~clk;    // 20 ns period
	end

	// lcg, upper bits only
	function int unsigned next_rand();
		rand_state = rand_state * 32'd1103515245 + 32'd12345;
		return (rand_state >> 16) & 32'h7fff;
	endfunction

	task step();
		@(posedge clk);
		#2;
	endtask

	// --------------------------------------------------
	// stimulus file
	// --------------------------------------------------
	task read_stim(output logic ok);
		int fd;
		int n;
		string text;
		string tag;
		int num, mode, fx, fy, pal, x, y, w, h, idx;
		int unsigned base, addr, data;
		sprite_pkg::sprite_attr_t ent;
		ok = 1'b0;
		fd = $fopen("tests/sprite_stim.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd))
			begin
				n = $fgets(text, fd);
				if ($sscanf(text, "%s", tag) != 1)
					continue;    // blank line
				if (tag == "A")
				begin
					n = $sscanf(text, "%s %d %d %d %d %d %d %d %d %d %h",
						tag, num, mode, fx, fy, pal, x, y, w, h, base);
					ent.mode = mode;
					ent.flipx = fx;
					ent.flipy = fy;
					ent.pal = pal;
					ent.x = x;
					ent.y = y;
					ent.width = w;
					ent.height = h;
					ent.base = base;
					if (n == 11 && num < `SPR_COUNT)
						attr_tab[num] = ent;
				end
				else if (tag == "P")
				begin
					if ($sscanf(text, "%s %d %d %h", tag, pal, idx, data) == 4)
						pal_tab[pal * 16 + idx] = data;
				end
				else if (tag == "M")
				begin
					if ($sscanf(text, "%s %h %h", tag, addr, data) == 3)
						mem_tab[addr % MEM_WORDS] = data;
				end
				else if (tag == "F")
					n = $sscanf(text, "%s %d", tag, frames);
			end
			$fclose(fd);
			ok = (frames > 0);
		end
	endtask

	task drive_host(input logic target, input int index, input logic [63:0] data);
		host_wr.valid = 1'b1;
		host_wr.target = target;
		host_wr.index = 9'(index);
		host_wr.data = data;
		step();
	endtask

	task load_host();
		for (int s = 0; s < `SPR_COUNT; s++)
			drive_host(sprite_pkg::TGT_ATTR, s, 64'(attr_tab[s]));
		for (int i = 0; i < `SPR_PAL_N * 16; i++)
			drive_host(sprite_pkg::TGT_PAL, i, 64'(pal_tab[i]));
		host_wr = '0;
	endtask

	// one scanline of video timing
	task run_line(input int k);
		line_start = 1'b1;
		frame_start = (k % LINES_PER_FRAME == 0);
		step();
		line_start = 1'b0;
		frame_start = 1'b0;
		for (int c = 1; c < LINE_CYC; c++)
		begin
			pix_tick = (c >= PIX_START && c < PIX_START + `SPR_LINE_W);
			step();
		end
		pix_tick = 1'b0;
	endtask

	// --------------------------------------------------
	// pixel memory model
	// --------------------------------------------------
	sprite_pkg::mem_addr_t pend [$];
	int lat_left = -1;

	initial
	begin
		logic req_hit;
		logic rsp_hit;
		sprite_pkg::mem_addr_t req_addr;
		fetch_ready = 1'b0;
		rsp_valid = 1'b0;
		rsp = '0;
		forever
		begin
			@(posedge clk);
			req_hit = fetch_valid && fetch_ready;
			req_addr = fetch_req.addr;
			rsp_hit = rsp_valid && rsp_ready;
			#2;
			if (rsp_hit)
			begin
				rsp_valid = 1'b0;
				void'(pend.pop_front());
			end
			if (req_hit)
				pend.push_back(req_addr);
			if (!rsp_valid && pend.size() > 0)
			begin
				if (lat_left < 0)
					lat_left = int'(next_rand() % 4);    // 1 to 4 cycles
				if (lat_left == 0)
				begin
					rsp.data = mem_tab[int'(pend[0]) % MEM_WORDS];
					rsp_valid = 1'b1;
					lat_left = -1;
				end
				else
					lat_left--;
			end
			fetch_ready = (next_rand() % 10) >= 3;    // low about 30 percent
		end
	end

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------
	initial
	begin
		logic stim_ok;
		longint limit;
		reset = 1'b1;
		line_start = 1'b0;
		frame_start = 1'b0;
		pix_tick = 1'b0;
		host_wr = '0;
		for (int i = 0; i < `SPR_COUNT; i++)
			attr_tab[i] = '0;
		for (int i = 0; i < `SPR_PAL_N * 16; i++)
			pal_tab[i] = '0;
		for (int i = 0; i < MEM_WORDS; i++)
			mem_tab[i] = '0;
		read_stim(stim_ok);
		if (!stim_ok)
		begin
			$display("could not read a frame count from tests/sprite_stim.txt");
			$display("Something failed");
			$finish;
		end
		else
		begin
			limit = longint'(frames) * LINES_PER_FRAME * LINE_CYC * 20 + 200000;
			fork
				begin
					#(limit);
					$display("timeout: run still going after %0d ns", limit);
					$display("Something failed");
					$finish;
				end
			join_none
			repeat (8) @(posedge clk);
			#2;
			reset = 1'b0;
			load_host();
			repeat (20) step();    // idle, nothing may show yet
			for (int k = 0; k < frames * LINES_PER_FRAME; k++)
				run_line(k);
			repeat (20) step();
			$display("closing: %0d pixels checked, %0d pixel errors, %0d other errors, %0d assertion failures",
				checked, pix_errors, other_errors, dut0.u_engine.chk0.fail_cnt);
			if (checked == 0)
				$display("no displayed pixel was compared");
			if (checked > 0 && pix_errors == 0 && other_errors == 0
				&& dut0.u_engine.chk0.fail_cnt == 0)
				$display("Everything OK");
			else
				$display("Something failed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+verilog
verilog/sprite_pkg.sv
verilog/sprite_attr_ram.sv
verilog/sprite_palette.sv
verilog/sprite_engine.sv
verilog/pixel_unpack.sv
verilog/line_buffer.sv
verilog/sprite_unit.sv
tests/sprite_checker.sv
tests/sprite_monitor.sv
tests/sprite_tb.sv

/* verilog/line_buffer.sv */
`include "sprite_cfg.svh"
`default_nettype none

// ping-pong scanline memory, render into one bank while the other is shown
module line_buffer (
	input  wire                        clk,
	input  wire                        reset,
	input  wire                        line_start,
	input  wire                        wr_en,
	input  wire sprite_pkg::xpos_t     wr_addr,
	input  wire sprite_pkg::color_t    wr_color,
	input  wire                        pix_tick,
	output sprite_pkg::color_t         pix_color,
	output logic                       pix_on
);

	logic disp_sel;                 // bank on display
	sprite_pkg::xpos_t rd_ptr;
	logic tick_d;
	logic tick_bank;                // bank read by the last tick
	logic [6:0] rd_entry;           // {occupied, colour}

	// --------------------------------------------------
	// banks
	// --------------------------------------------------
	for (genvar b = 0; b < 2; b++)
	begin : g_bank
		logic [6:0] mem [`SPR_LINE_W];
		logic [6:0] rd_q;
		logic shown;

		assign shown = (disp_sel == 1'(b));

		always_ff @(posedge clk)
		begin
			if (shown)
			begin
				if (pix_tick)
				begin
					rd_q <= mem[rd_ptr];
					mem[rd_ptr] <= '0;    // empty for its next build
				end
			end
			else if (wr_en)
				mem[wr_addr] <= {1'b1, wr_color};    // later sprites overwrite
		end
	end

	assign rd_entry = tick_bank ? g_bank[1].rd_q : g_bank[0].rd_q;

	// --------------------------------------------------
	// display side
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			disp_sel <= 1'b0;
			rd_ptr <= '0;
			tick_d <= 1'b0;
			pix_on <= 1'b0;
		end
		else
		begin
			if (line_start)
			begin
				disp_sel <= !disp_sel;    // swap build and show
				rd_ptr <= '0;
			end
			else if (pix_tick)
				rd_ptr <= rd_ptr + 1'b1;
			tick_d <= pix_tick;
			pix_on <= tick_d && rd_entry[6];    // 2 cycles after tick
		end
	end

	always_ff @(posedge clk)
	begin
		if (pix_tick)
			tick_bank <= disp_sel;
		if (tick_d)
			pix_color <= rd_entry[5:0];
	end

endmodule

`default_nettype wire

/* verilog/pixel_unpack.sv */
`include "sprite_cfg.svh"
`default_nettype none

module pixel_unpack (
	input  wire                         clk,
	input  wire                         reset,
	input  wire                         job_valid,
	input  wire sprite_pkg::word_job_t  job,
	output logic                        job_ready,
	output sprite_pkg::pal_t            pal_sel,
	output sprite_pkg::pix_idx_t        pal_idx,
	input  wire sprite_pkg::color_t     pal_color,
	output logic                        wr_en,
	output sprite_pkg::xpos_t           wr_addr,
	output sprite_pkg::color_t          wr_color
);

	logic busy;
	logic [2:0] cnt;                 // pixels left in word minus one
	sprite_pkg::mem_word_t shreg;
	logic mode16;
	logic flipx;
	sprite_pkg::pal_t pal;
	logic [9:0] pos;                 // extra bit so runs past the edge clip
	logic take;
	logic pix_ok;

	assign job_ready = !busy;
	assign take = job_valid && !busy;

	// msb first
	assign pal_sel = pal;
	assign pal_idx = mode16 ? shreg[15:12] : {2'b00, shreg[15:14]};
	assign pix_ok = busy && (pal_idx != '0) && (pos < `SPR_LINE_W);    // 0 is transparent

	assign wr_color = pal_color;    // palette output lines up with wr_en

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			wr_en <= 1'b0;
		end
		else
		begin
			wr_en <= pix_ok;
			if (take)
			begin
				busy <= 1'b1;
				cnt <= (job.mode == sprite_pkg::MODE_16C) ? 3'd3 : 3'd7;
			end
			else if (busy)
			begin
				if (cnt == 3'd0)
					busy <= 1'b0;
				cnt <= cnt - 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// shifter and running position
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (take)
		begin
			shreg <= job.word;
			mode16 <= (job.mode == sprite_pkg::MODE_16C);
			flipx <= job.flipx;
			pal <= job.pal;
			if (job.first)
				pos <= {1'b0, job.start};    // else continue from last word
		end
		else if (busy)
		begin
			shreg <= mode16 ? (shreg << 4) : (shreg << 2);
			pos <= flipx ? (pos - 1'b1) : (pos + 1'b1);
		end
		wr_addr <= pos[8:0];
	end

endmodule

`default_nettype wire

/* verilog/sprite_attr_ram.sv */
`include "sprite_cfg.svh"
`default_nettype none

// sprite attribute file, one packed entry per sprite
module sprite_attr_ram (
	input  wire                           clk,
	input  wire sprite_pkg::host_wr_t     host_wr,
	input  wire sprite_pkg::spr_num_t     rd_num,
	output sprite_pkg::sprite_attr_t      rd_attr
);

	sprite_pkg::sprite_attr_t mem [`SPR_COUNT];
	logic attr_we;

	// only attribute writes land here
	assign attr_we = host_wr.valid && (host_wr.target == sprite_pkg::TGT_ATTR);

	always_ff @(posedge clk)
	begin
		if (attr_we)
			mem[sprite_pkg::spr_num_t'(host_wr.index)] <=
				host_wr.data[$bits(sprite_pkg::sprite_attr_t)-1:0];
		rd_attr <= mem[rd_num];    // one cycle read
	end

endmodule

`default_nettype wire

/* verilog/sprite_cfg.svh */
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

`default_nettype none

// --------------------------------------------------
// sprite unit sizing
// --------------------------------------------------

`define SPR_COUNT   32     // entries in the attribute file
`define SPR_LINE_W  320    // visible pixels per scanline
`define SPR_MEM_AW  20     // pixel memory word address bits
`define SPR_PAL_N   16     // palettes of 16 colours each

`default_nettype wire

`endif

/* verilog/sprite_engine.sv */
`include "sprite_cfg.svh"
`default_nettype none

module sprite_engine (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           line_start,
	input  wire                           frame_start,
	output sprite_pkg::spr_num_t          attr_num,
	input  wire sprite_pkg::sprite_attr_t attr,
	output logic                          fetch_valid,
	output sprite_pkg::fetch_req_t        fetch_req,
	input  wire                           fetch_ready,
	input  wire                           rsp_valid,
	input  wire sprite_pkg::fetch_rsp_t   rsp,
	output logic                          rsp_ready,
	output logic                          job_valid,
	output sprite_pkg::word_job_t         job,
	input  wire                           job_ready
);

	sprite_pkg::eng_state_t state;
	sprite_pkg::line_t build_line;     // line under construction
	sprite_pkg::spr_num_t num;
	logic restart;                     // leave wait_done into a new scan
	logic drop;                        // pending response belongs to an aborted line
	logic outstanding;
	logic first_pend;
	sprite_pkg::mem_addr_t addr;
	logic [5:0] words_left;
	sprite_pkg::spr_mode_t cur_mode;
	sprite_pkg::pal_t cur_pal;
	logic cur_flipx;
	sprite_pkg::xpos_t cur_start;

	sprite_pkg::line_t row_raw;
	logic [7:0] row_sel;
	logic [13:0] row_ofs;
	sprite_pkg::xpos_t span;
	logic visible;
	logic last_num;
	logic issue;
	logic fetch_take;
	logic rsp_take;

	assign attr_num = num;
	assign rsp_ready = outstanding;    // only while a request is out
	assign fetch_take = fetch_valid && fetch_ready;
	assign rsp_take = rsp_valid && rsp_ready;
	assign last_num = (num == sprite_pkg::spr_num_t'(`SPR_COUNT - 1));

	// --------------------------------------------------
	// visibility and row address
	// --------------------------------------------------
	assign row_raw = build_line - attr.y;
	assign visible = (attr.mode != sprite_pkg::MODE_OFF) && (attr.width != '0)
		&& (build_line >= attr.y) && (row_raw < {1'b0, attr.height});
	assign row_sel = attr.flipy ? (attr.height - 8'd1 - row_raw[7:0]) : row_raw[7:0];
	assign row_ofs = row_sel * attr.width;
	// sprite width in pixels
	assign span = (attr.mode == sprite_pkg::MODE_16C) ? {1'b0, attr.width, 2'b00}
		: {attr.width, 3'b000};

	// one word at a time, and never while the job register is full
	assign issue = (state == sprite_pkg::ST_FETCH) && !fetch_valid && !outstanding && !job_valid;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sprite_pkg::ST_IDLE;
			build_line <= '0;
			num <= '0;
			restart <= 1'b0;
			drop <= 1'b0;
			outstanding <= 1'b0;
			fetch_valid <= 1'b0;
			job_valid <= 1'b0;
			first_pend <= 1'b0;
		end
		else
		begin
			// handshakes proceed in every state
			if (fetch_take)
			begin
				fetch_valid <= 1'b0;
				outstanding <= 1'b1;
			end
			if (job_valid && job_ready)
				job_valid <= 1'b0;
			if (rsp_take)
			begin
				outstanding <= 1'b0;
				drop <= 1'b0;
				if (!drop && !line_start)
					job_valid <= 1'b1;    // word into job register
			end

			if (line_start)
			begin
				build_line <= frame_start ? '0 : build_line + 1'b1;
				num <= '0;
				job_valid <= 1'b0;            // queued word is for the old line
				if (fetch_valid || (outstanding && !rsp_take))
					drop <= 1'b1;             // its response still comes back
				restart <= 1'b1;
				state <= sprite_pkg::ST_WAIT_DONE;
			end
			else
			begin
				case (state)
					sprite_pkg::ST_IDLE: ;
					sprite_pkg::ST_READ_ATTR:
						state <= sprite_pkg::ST_CHECK;    // attr ram latency
					sprite_pkg::ST_CHECK:
					begin
						if (visible)
						begin
							first_pend <= 1'b1;
							state <= sprite_pkg::ST_FETCH;
						end
						else if (last_num)
							state <= sprite_pkg::ST_WAIT_DONE;
						else
						begin
							num <= num + 1'b1;
							state <= sprite_pkg::ST_READ_ATTR;
						end
					end
					sprite_pkg::ST_FETCH:
					begin
						if (issue)
						begin
							fetch_valid <= 1'b1;
							first_pend <= 1'b0;
							if (words_left == 6'd1)    // last word of this row
							begin
								if (last_num)
									state <= sprite_pkg::ST_WAIT_DONE;
								else
								begin
									num <= num + 1'b1;
									state <= sprite_pkg::ST_READ_ATTR;
								end
							end
						end
					end
					sprite_pkg::ST_WAIT_DONE:
					begin
						// drain request, response and job before moving on
						if (!fetch_valid && !outstanding && !job_valid)
						begin
							state <= restart ? sprite_pkg::ST_READ_ATTR : sprite_pkg::ST_IDLE;
							restart <= 1'b0;
						end
					end
					default: state <= sprite_pkg::ST_IDLE;
				endcase
			end
		end
	end

	// --------------------------------------------------
	// address, sprite fields and job payload
	// --------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (state == sprite_pkg::ST_CHECK)
		begin
			addr <= attr.base + sprite_pkg::mem_addr_t'(row_ofs);
			words_left <= attr.width;
			cur_mode <= attr.mode;
			cur_pal <= attr.pal;
			cur_flipx <= attr.flipx;
			cur_start <= attr.flipx ? (attr.x + span - 1'b1) : attr.x;    // right edge
		end
		if (issue)
		begin
			fetch_req.addr <= addr;
			addr <= addr + 1'b1;
			words_left <= words_left - 1'b1;
			// job register is free here so the word's context goes in now
			job.mode <= cur_mode;
			job.pal <= cur_pal;
			job.flipx <= cur_flipx;
			job.start <= cur_start;
			job.first <= first_pend;
		end
		if (rsp_take)
			job.word <= rsp.data;
	end

endmodule

`default_nettype wire

/* verilog/sprite_palette.sv */
`include "sprite_cfg.svh"
`default_nettype none

// palette ram, indexed by {palette, pixel index}
module sprite_palette (
	input  wire                        clk,
	input  wire sprite_pkg::host_wr_t  host_wr,
	input  wire sprite_pkg::pal_t      rd_pal,
	input  wire sprite_pkg::pix_idx_t  rd_idx,
	output sprite_pkg::color_t         rd_color
);

	localparam int PAL_DEPTH = `SPR_PAL_N * 16;
	localparam int PAL_AW = $clog2(PAL_DEPTH);

	sprite_pkg::color_t mem [PAL_DEPTH];
	logic pal_we;

	assign pal_we = host_wr.valid && (host_wr.target == sprite_pkg::TGT_PAL);

	always_ff @(posedge clk)
	begin
		if (pal_we)
			mem[host_wr.index[PAL_AW-1:0]] <= host_wr.data[$bits(sprite_pkg::color_t)-1:0];
		rd_color <= mem[{rd_pal, rd_idx}];    // registered read for the unpacker
	end

endmodule

`default_nettype wire

/* verilog/sprite_pkg.sv */
`include "sprite_cfg.svh"
`default_nettype none

package sprite_pkg;

	// --------------------------------------------------
	// widths
	// --------------------------------------------------
	typedef logic [8:0] xpos_t;                    // pixel column
	typedef logic [8:0] line_t;                    // scanline number
	typedef logic [5:0] color_t;                   // display colour
	typedef logic [3:0] pix_idx_t;                 // index before palette
	typedef logic [3:0] pal_t;                     // palette select
	typedef logic [`SPR_MEM_AW-1:0] mem_addr_t;    // pixel memory word addr
	typedef logic [15:0] mem_word_t;
	typedef logic [4:0] spr_num_t;
	typedef logic [1:0] spr_mode_t;

	// colour modes
	localparam spr_mode_t MODE_OFF = 2'd0;   // sprite inactive
	localparam spr_mode_t MODE_4C = 2'd1;    // 8 pixels of 2 bits per word
	localparam spr_mode_t MODE_16C = 2'd2;   // 4 pixels of 4 bits per word

	// host write targets
	localparam logic TGT_ATTR = 1'b0;
	localparam logic TGT_PAL = 1'b1;

	// --------------------------------------------------
	// structs
	// --------------------------------------------------
	typedef struct packed {
		spr_mode_t mode;
		logic      flipx;
		logic      flipy;
		pal_t      pal;
		xpos_t     x;
		line_t     y;
		logic [5:0] width;   // in words
		logic [7:0] height;  // in lines
		mem_addr_t base;     // word address of row 0
	} sprite_attr_t;

	typedef struct packed {
		logic        valid;
		logic        target;
		logic [8:0]  index;
		logic [63:0] data;    // palette takes the low colour bits
	} host_wr_t;

	typedef struct packed {
		mem_addr_t addr;
	} fetch_req_t;

	typedef struct packed {
		mem_word_t data;
	} fetch_rsp_t;

	// one fetched word plus what the unpacker needs to place it
	typedef struct packed {
		mem_word_t word;
		spr_mode_t mode;
		pal_t      pal;
		logic      flipx;
		xpos_t     start;   // reload position on first word
		logic      first;
	} word_job_t;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_READ_ATTR,
		ST_CHECK,
		ST_FETCH,
		ST_WAIT_DONE
	} eng_state_t;

endpackage

`default_nettype wire

/* verilog/sprite_unit.sv */
`default_nettype none

module sprite_unit (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          line_start,
	input  wire                          frame_start,
	input  wire                          pix_tick,
	input  wire sprite_pkg::host_wr_t    host_wr,
	output logic                         fetch_valid,
	output sprite_pkg::fetch_req_t       fetch_req,
	input  wire                          fetch_ready,
	input  wire                          rsp_valid,
	input  wire sprite_pkg::fetch_rsp_t  rsp,
	output logic                         rsp_ready,
	output sprite_pkg::color_t           pix_color,
	output logic                         pix_on
);

	sprite_pkg::spr_num_t attr_num;
	sprite_pkg::sprite_attr_t attr;
	logic job_valid;
	sprite_pkg::word_job_t job;
	logic job_ready;
	sprite_pkg::pal_t pal_sel;
	sprite_pkg::pix_idx_t pal_idx;
	sprite_pkg::color_t pal_color;
	logic wr_en;
	sprite_pkg::xpos_t wr_addr;
	sprite_pkg::color_t wr_color;

	sprite_attr_ram u_attr (
		.clk     (clk),
		.host_wr (host_wr),
		.rd_num  (attr_num),
		.rd_attr (attr)
	);

	// scan, fetch and job issue
	sprite_engine u_engine (
		.clk         (clk),
		.reset       (reset),
		.line_start  (line_start),
		.frame_start (frame_start),
		.attr_num    (attr_num),
		.attr        (attr),
		.fetch_valid (fetch_valid),
		.fetch_req   (fetch_req),
		.fetch_ready (fetch_ready),
		.rsp_valid   (rsp_valid),
		.rsp         (rsp),
		.rsp_ready   (rsp_ready),
		.job_valid   (job_valid),
		.job         (job),
		.job_ready   (job_ready)
	);

	pixel_unpack u_unpack (
		.clk       (clk),
		.reset     (reset),
		.job_valid (job_valid),
		.job       (job),
		.job_ready (job_ready),
		.pal_sel   (pal_sel),
		.pal_idx   (pal_idx),
		.pal_color (pal_color),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_color  (wr_color)
	);

	sprite_palette u_palette (
		.clk      (clk),
		.host_wr  (host_wr),
		.rd_pal   (pal_sel),
		.rd_idx   (pal_idx),
		.rd_color (pal_color)
	);

	// build and display banks
	line_buffer u_line (
		.clk        (clk),
		.reset      (reset),
		.line_start (line_start),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_color   (wr_color),
		.pix_tick   (pix_tick),
		.pix_color  (pix_color),
		.pix_on     (pix_on)
	);

endmodule

`default_nettype wire
